/* source/uram_readout_pkg.sv */
package uram_readout_pkg;

    // buffer geometry, the buffer holds 2**ADDR_BITS samples
    localparam int ADDR_BITS = 10;
    localparam int DATA_BITS = 32;
    localparam int BUF_DEPTH = 1 << ADDR_BITS;

    // cycles from an address at the read port to its data at the output
    // the memory registers the address and then the data, so two stages
    localparam int READ_LATENCY = 2;

    // width of the accepted and dropped trigger counters
    localparam int STAT_BITS = 16;

    // one write into the sample buffer
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] data;
    } buf_wr_t;

    // one word leaving the readout block
    // first marks the opening word of an event and last the closing one
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 first;
        logic                 last;
    } readout_word_t;

    // sequencer states
    // RUN waits for the first word of the event to come out,
    // DRAIN waits for the word that carries the last flag
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } readout_state_e;

endpackage

/* source/uram_read_counter.sv */
`timescale 1ns/1ns

module uram_read_counter
    import uram_readout_pkg::*;
#(
    parameter int COUNT_MAX = 171
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 run_i,
    input  logic [ADDR_BITS-1:0] start_addr_i,
    output logic                 addr_valid_o,
    output logic [ADDR_BITS-1:0] addr_o,
    output logic                 complete_o
);

    // the remaining count has to hold COUNT_MAX-1, and at least one bit
    // is needed even when COUNT_MAX is 1
    localparam int CNT_BITS = $clog2(COUNT_MAX + 1);

    // active is high for exactly COUNT_MAX cycles after a run pulse
    logic                active;
    logic [ADDR_BITS-1:0] addr_q;
    // counts down and reaches zero on the last address of the event
    logic [CNT_BITS-1:0]  remaining;

    // the last address is the one presented while the count sits at zero
    assign complete_o   = active && (remaining == '0);
    assign addr_valid_o = active;
    assign addr_o       = addr_q;

    // control state, cleared by reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active <= 1'b0;
        end else if (!active) begin
            // a run pulse starts an event on the next cycle
            active <= run_i;
        end else if (remaining == '0) begin
            // the final address has just gone out
            active <= 1'b0;
        end
    end

    // address and count of the event in progress
    always_ff @(posedge clk_i) begin
        if (!active) begin
            if (run_i) begin
                addr_q    <= start_addr_i;
                remaining <= CNT_BITS'(COUNT_MAX - 1);
            end
        end else if (remaining != '0) begin
            // the address wraps by itself at the buffer depth since it is
            // exactly ADDR_BITS wide
            addr_q    <= addr_q + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

    // a run pulse while active is ignored because the sequencer
    // only issues one from its idle state

endmodule

/* source/sample_buffer.sv */
`timescale 1ns/1ns

module sample_buffer
    import uram_readout_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 wr_en_i,
    input  buf_wr_t              wr_req_i,
    input  logic [ADDR_BITS-1:0] rd_addr_i,
    output logic [DATA_BITS-1:0] rd_data_o
);

    // the sample store itself
    // like the block memory it models it has no reset, so unwritten
    // words come back undefined
    logic [DATA_BITS-1:0] mem [BUF_DEPTH];

    // read pipeline, first the address is captured and then the data
    logic [ADDR_BITS-1:0] rd_addr_q;
    logic [DATA_BITS-1:0] rd_data_q;

    // synchronous write port
    // the write lands at the edge where the strobe is sampled
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_req_i.addr] <= wr_req_i.data;
        end
    end

    // first read stage registers the address presented this cycle
    always_ff @(posedge clk_i) begin
        rd_addr_q <= rd_addr_i;
    end

    // second read stage is the output register of the memory
    // together with the address stage this gives READ_LATENCY of two
    always_ff @(posedge clk_i) begin
        rd_data_q <= mem[rd_addr_q];
    end

    // a write and a read to the same word in the same cycle are
    // not ordered here, the behaviour there is left open

    assign rd_data_o = rd_data_q;

endmodule

/* source/readout_word_aligner.sv */
`timescale 1ns/1ns

module readout_word_aligner
    import uram_readout_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 addr_valid_i,
    input  logic                 complete_i,
    input  logic [DATA_BITS-1:0] rd_data_i,
    output logic                 word_valid_o,
    output readout_word_t        word_o
);

    // delay lines for the strobes, one stage per memory pipeline stage
    // several addresses of an event are in flight at once, one per stage
    logic [READ_LATENCY-1:0] valid_sr;
    logic [READ_LATENCY-1:0] complete_sr;

    // strobes lined up with the data at the memory output
    logic valid_d;
    logic complete_d;

    // valid of the word before the current one, used to find the
    // opening word of an event
    logic prev_valid;

    assign valid_d    = valid_sr[READ_LATENCY-1];
    assign complete_d = complete_sr[READ_LATENCY-1];

    // shift the strobes along with the read pipeline
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_sr    <= '0;
            complete_sr <= '0;
            prev_valid  <= 1'b0;
        end else begin
            valid_sr[0]    <= addr_valid_i;
            complete_sr[0] <= complete_i;
            for (int i = 1; i < READ_LATENCY; i++) begin
                valid_sr[i]    <= valid_sr[i-1];
                complete_sr[i] <= complete_sr[i-1];
            end
            prev_valid <= valid_d;
        end
    end

    // the data comes straight from the memory output register
    assign word_valid_o = valid_d;
    assign word_o.data  = rd_data_i;

    // events never run back to back without a gap, so a valid word
    // whose predecessor was idle is always the first of its event
    assign word_o.first = valid_d && !prev_valid;

    // the counter raises complete with the last address, so the delayed
    // strobe lands on the last word
    assign word_o.last  = complete_d;

endmodule

/* source/readout_sequencer.sv */
`timescale 1ns/1ns

module readout_sequencer
    import uram_readout_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 trigger_i,
    input  logic [ADDR_BITS-1:0] trig_addr_i,
    input  logic                 out_valid_i,
    input  logic                 out_last_i,
    output logic                 run_o,
    output logic [ADDR_BITS-1:0] start_addr_o,
    output logic                 busy_o,
    output logic [STAT_BITS-1:0] accepted_count_o,
    output logic [STAT_BITS-1:0] dropped_count_o
);

    readout_state_e state;
    readout_state_e state_next;

    // a trigger is taken only from idle, anything else is dropped
    logic accept;
    logic drop;
    // the closing word of the event is at the output this cycle
    logic last_seen;

    assign accept    = trigger_i && (state == IDLE);
    assign drop      = trigger_i && (state != IDLE);
    assign last_seen = out_valid_i && out_last_i;

    // busy covers everything from the cycle after the trigger up to and
    // including the last output word
    assign busy_o = (state != IDLE);

    // next state
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                // a single word event can end right on its first word
                if (last_seen) begin
                    state_next = IDLE;
                end else if (out_valid_i) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                if (last_seen) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // state, run pulse and counters
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state            <= IDLE;
            run_o            <= 1'b0;
            accepted_count_o <= '0;
            dropped_count_o  <= '0;
        end else begin
            state <= state_next;
            // run is high for exactly the cycle after an accepted trigger
            run_o <= accept;
            // both counters simply wrap when they overflow
            if (accept) begin
                accepted_count_o <= accepted_count_o + 1'b1;
            end
            if (drop) begin
                dropped_count_o <= dropped_count_o + 1'b1;
            end
        end
    end

    // start address is payload, it only matters while run is high
    always_ff @(posedge clk_i) begin
        if (accept) begin
            start_addr_o <= trig_addr_i;
        end
    end

endmodule

/* source/uram_readout_top.sv */
`timescale 1ns/1ns

module uram_readout_top
    import uram_readout_pkg::*;
#(
    // words per event, anything from 1 up to the buffer depth
    parameter int COUNT_MAX = 171
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 wr_en_i,
    input  buf_wr_t              wr_req_i,
    input  logic                 trigger_i,
    input  logic [ADDR_BITS-1:0] trig_addr_i,
    output logic                 word_valid_o,
    output readout_word_t        word_o,
    output logic                 busy_o,
    output logic [STAT_BITS-1:0] accepted_count_o,
    output logic [STAT_BITS-1:0] dropped_count_o
);

    // sequencer to counter
    logic                 run;
    logic [ADDR_BITS-1:0] start_addr;

    // counter to buffer and aligner
    logic                 addr_valid;
    logic [ADDR_BITS-1:0] rd_addr;
    logic                 complete;

    // buffer to aligner
    logic [DATA_BITS-1:0] rd_data;

    // takes triggers and holds busy until the event has left
    // the aligner output feeds back here so the last word ends busy
    readout_sequencer u_sequencer (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .trigger_i        (trigger_i),
        .trig_addr_i      (trig_addr_i),
        .out_valid_i      (word_valid_o),
        .out_last_i       (word_o.last),
        .run_o            (run),
        .start_addr_o     (start_addr),
        .busy_o           (busy_o),
        .accepted_count_o (accepted_count_o),
        .dropped_count_o  (dropped_count_o)
    );

    // walks COUNT_MAX wrapping addresses from the start address
    uram_read_counter #(
        .COUNT_MAX (COUNT_MAX)
    ) u_read_counter (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .run_i        (run),
        .start_addr_i (start_addr),
        .addr_valid_o (addr_valid),
        .addr_o       (rd_addr),
        .complete_o   (complete)
    );

    // the sample memory, written by the producer and read by the counter
    sample_buffer u_sample_buffer (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en_i),
        .wr_req_i  (wr_req_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    // brings the strobes in line with the read data and sets the flags
    readout_word_aligner u_word_aligner (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .addr_valid_i (addr_valid),
        .complete_i   (complete),
        .rd_data_i    (rd_data),
        .word_valid_o (word_valid_o),
        .word_o       (word_o)
    );

endmodule

/* verification/tb_uram_readout.sv */
`timescale 1ns/1ns

module tb_uram_readout
    import uram_readout_pkg::*;
;

    localparam int COUNT_MAX = 171;
    // twelve events worth of cycles plus room for filling the buffer
    localparam int TIMEOUT_CYCLES = 12 * (COUNT_MAX + 10) + 1500;

    logic                 clk_i = 1'b0;
    logic                 reset_i;
    logic                 wr_en_i;
    buf_wr_t              wr_req_i;
    logic                 trigger_i;
    logic [ADDR_BITS-1:0] trig_addr_i;
    logic                 word_valid_o;
    readout_word_t        word_o;
    logic                 busy_o;
    logic [STAT_BITS-1:0] accepted_count_o;
    logic [STAT_BITS-1:0] dropped_count_o;

    // mirror of every write that reached the buffer
    logic [DATA_BITS-1:0] shadow [BUF_DEPTH];

    // reference model of the event in flight and of the counters
    int   cycle_count = 0;
    logic ev_active = 1'b0;
    logic [ADDR_BITS-1:0] ev_start = '0;
    int   ev_trig_edge = 0;
    int   exp_accepted = 0;
    int   exp_dropped = 0;
    // valid words that the DUT actually put out
    int   words_seen = 0;

    // what the stimulus meant to happen, kept apart from the model above
    int   triggers_sent = 0;
    int   drops_sent = 0;
    integer seed = 32'h4f02_ad15;

    uram_readout_top #(
        .COUNT_MAX (COUNT_MAX)
    ) u_uram_readout_top (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .wr_en_i          (wr_en_i),
        .wr_req_i         (wr_req_i),
        .trigger_i        (trigger_i),
        .trig_addr_i      (trig_addr_i),
        .word_valid_o     (word_valid_o),
        .word_o           (word_o),
        .busy_o           (busy_o),
        .accepted_count_o (accepted_count_o),
        .dropped_count_o  (dropped_count_o)
    );

    initial begin
        forever #4 clk_i = ~clk_i;
    end

    // expected sample for word idx of an event, taken from the shadow
    // copy and wrapping at the buffer depth
    function automatic logic [DATA_BITS-1:0] expected_sample(input logic [ADDR_BITS-1:0] start,
                                                             input int idx);
        int addr;
        addr = (int'(start) + idx) % BUF_DEPTH;
        return shadow[addr];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expect_val);
        $display("[ERROR] %s: got 0x%h, expected 0x%h at cycle %0d",
                 name, got, expect_val, cycle_count);
        $display("Testbench failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    // free running cycle count that also ends a hung run
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Testbench failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // compares every cycle's outputs with the model, then lets the model
    // take in what the DUT samples at this same edge
    always @(posedge clk_i) begin : compare_outputs
        int idx;
        logic exp_busy;
        logic exp_valid;
        logic [DATA_BITS-1:0] exp_data;
        if (!reset_i) begin
            // busy runs from the cycle after the trigger through the last word
            exp_busy = ev_active && (cycle_count > ev_trig_edge) &&
                       (cycle_count <= ev_trig_edge + 3 + COUNT_MAX);
            // words show up 4 cycles after the trigger edge, one per cycle
            exp_valid = ev_active && (cycle_count >= ev_trig_edge + 4) &&
                        (cycle_count <= ev_trig_edge + 3 + COUNT_MAX);
            assert (busy_o === exp_busy)
                else report_mismatch("busy_o", 32'(busy_o), 32'(exp_busy));
            assert (word_valid_o === exp_valid)
                else report_mismatch("word_valid_o", 32'(word_valid_o), 32'(exp_valid));
            if (exp_valid) begin
                idx = cycle_count - (ev_trig_edge + 4);
                exp_data = expected_sample(ev_start, idx);
                assert (word_o.data === exp_data)
                    else report_mismatch("word_o.data", word_o.data, exp_data);
                assert (word_o.first === (idx == 0))
                    else report_mismatch("word_o.first", 32'(word_o.first), 32'(idx == 0));
                assert (word_o.last === (idx == COUNT_MAX - 1))
                    else report_mismatch("word_o.last", 32'(word_o.last),
                                         32'(idx == COUNT_MAX - 1));
            end
            if (word_valid_o === 1'b1) begin
                words_seen++;
            end
            assert (accepted_count_o === STAT_BITS'(exp_accepted))
                else report_mismatch("accepted_count_o", 32'(accepted_count_o),
                                     32'(exp_accepted));
            assert (dropped_count_o === STAT_BITS'(exp_dropped))
                else report_mismatch("dropped_count_o", 32'(dropped_count_o),
                                     32'(exp_dropped));
            // a trigger while busy is dropped, otherwise it opens a new event
            if (trigger_i) begin
                if (exp_busy) begin
                    exp_dropped++;
                end else begin
                    exp_accepted++;
                    ev_active    = 1'b1;
                    ev_start     = trig_addr_i;
                    ev_trig_edge = cycle_count;
                end
            end
            // the write lands at this edge and later reads see it
            if (wr_en_i) begin
                shadow[wr_req_i.addr] = wr_req_i.data;
            end
        end
    end

    // all stimulus tasks start and end just after a falling edge
    task automatic write_word(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data);
        wr_en_i       = 1'b1;
        wr_req_i.addr = addr;
        wr_req_i.data = data;
        @(negedge clk_i);
        wr_en_i = 1'b0;
    endtask

    task automatic fill_buffer();
        logic [DATA_BITS-1:0] rnd;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            rnd = $random(seed);
            write_word(ADDR_BITS'(i), rnd);
        end
    endtask

    task automatic fire_trigger(input logic [ADDR_BITS-1:0] addr);
        trigger_i   = 1'b1;
        trig_addr_i = addr;
        @(negedge clk_i);
        trigger_i = 1'b0;
    endtask

    // a trigger meant to be dropped carries a random address that must not matter
    task automatic fire_dropped_trigger();
        logic [31:0] rnd;
        rnd = $random(seed);
        fire_trigger(rnd[ADDR_BITS-1:0]);
        drops_sent++;
    endtask

    task automatic wait_idle();
        while (busy_o) begin
            @(negedge clk_i);
        end
    endtask

    // new samples near and inside the range of the next event are written
    // before the event itself starts
    task automatic event_after_writes(input logic [ADDR_BITS-1:0] start);
        logic [31:0] rnd;
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            // the even writes land inside the range the event will read
            if (i % 2 == 0) begin
                write_word(start + ADDR_BITS'(rnd[15:0] % COUNT_MAX), $random(seed));
            end else begin
                write_word(rnd[ADDR_BITS-1:0], $random(seed));
            end
        end
        fire_trigger(start);
        triggers_sent++;
        wait_idle();
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        reset_i     = 1'b1;
        wr_en_i     = 1'b0;
        wr_req_i    = '0;
        trigger_i   = 1'b0;
        trig_addr_i = '0;
        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;

        // every word has to be written before it can be read back
        fill_buffer();

        // single event from a low address
        fire_trigger(ADDR_BITS'(37));
        triggers_sent++;
        wait_idle();

        // this one runs past the top of the buffer and wraps to address 0
        fire_trigger(ADDR_BITS'(1000));
        triggers_sent++;
        wait_idle();

        // triggers while busy come right after the accepted one, in the middle
        // and on the last busy cycle
        rnd = $random(seed);
        fire_trigger(rnd[ADDR_BITS-1:0]);
        triggers_sent++;
        fire_dropped_trigger();
        repeat (60) @(negedge clk_i);
        fire_dropped_trigger();
        while (!(word_valid_o && word_o.last)) begin
            @(negedge clk_i);
        end
        fire_dropped_trigger();

        // back to back events with each trigger on the first idle cycle
        for (int i = 0; i < 2; i++) begin
            wait_idle();
            rnd = $random(seed);
            fire_trigger(rnd[ADDR_BITS-1:0]);
            triggers_sent++;
        end
        wait_idle();

        // events with fresh writes between them
        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            event_after_writes(rnd[ADDR_BITS-1:0]);
        end

        repeat (4) @(negedge clk_i);
        assert (accepted_count_o === STAT_BITS'(triggers_sent))
            else report_mismatch("accepted_count_o", 32'(accepted_count_o), 32'(triggers_sent));
        assert (dropped_count_o === STAT_BITS'(drops_sent))
            else report_mismatch("dropped_count_o", 32'(dropped_count_o), 32'(drops_sent));
        assert (words_seen == triggers_sent * COUNT_MAX)
            else report_mismatch("word count", 32'(words_seen), 32'(triggers_sent * COUNT_MAX));
        $display("Testbench passed");
        $finish;
    end

endmodule

/* filelist.f */
source/uram_readout_pkg.sv
source/uram_read_counter.sv
source/sample_buffer.sv
source/readout_word_aligner.sv
source/readout_sequencer.sv
source/uram_readout_top.sv
verification/tb_uram_readout.sv

/* Makefile */
TB  := tb_uram_readout
SRC := $(wildcard source/*.sv) verification/tb_uram_readout.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TB): filelist.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB) -f filelist.f

# the simulator exits with a failing status on any $fatal
run: obj_dir/V$(TB)
	./obj_dir/V$(TB)

lint:
	verilator --lint-only -Wall --top-module uram_readout_top \
		source/uram_readout_pkg.sv source/uram_read_counter.sv \
		source/sample_buffer.sv source/readout_word_aligner.sv \
		source/readout_sequencer.sv source/uram_readout_top.sv

clean:
	rm -rf obj_dir
